// File: include/io_params.svh
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// Word width N of every decompressed word and bank entry.
`define IO_WORD_W 32

// Words per bank, a power of two. Each lane of a pair owns one half.
`define IO_BANK_DEPTH 64

// Cycles allowed per code bit when the testbench sizes its timeout.
`define IO_TIMEOUT_BASE 8

`endif

// File: src/io_bus_pkg.sv
package io_bus_pkg;

  // Stream tag carried with every code byte.
  typedef enum logic [1:0] {
    STREAM_A    = 2'd0,
    STREAM_B    = 2'd1,
    STREAM_U    = 2'd2,
    STREAM_CTRL = 2'd3
  } stream_t;

  // One host transfer. Code bit 7 is reserved, bit 6 the value, bits 5:0 the run.
  typedef struct packed {
    stream_t    stream;
    logic       eob;
    logic [7:0] code;
  } host_pkt_t;

  // Command handed to a single decompressor lane.
  typedef struct packed {
    logic       value;
    logic [5:0] run;
    logic       eob;
  } lane_cmd_t;

endpackage

// File: src/io_mem_pkg.sv
`include "io_params.svh"

package io_mem_pkg;

  localparam int ADDR_W = $clog2(`IO_BANK_DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;

  // The top address bit selects the half of the bank.
  typedef struct packed {
    addr_t                 addr;
    logic [`IO_WORD_W-1:0] data;
  } wr_req_t;

endpackage

// File: src/io_fsm.sv
`timescale 1ns/1ps

module io_fsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  io_bus_pkg::host_pkt_t pkt,
  output logic                  ack,
  input  logic [3:0]            lane_idle,
  output logic [3:0]            lane_load,
  output io_bus_pkg::lane_cmd_t lane_cmd
);

  typedef enum logic [1:0] {
    S_WAIT_REQ,
    S_ACKED,
    S_WAIT_LOW
  } state_t;

  state_t state;
  logic   accept;

  assign accept = (state == S_WAIT_REQ) && req && lane_idle[pkt.stream]; // Busy lane stalls ack.

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state     <= S_WAIT_REQ;
      ack       <= 1'b0;
      lane_load <= '0;
    end
    else
    begin
      lane_load <= '0;
      case (state)
        S_WAIT_REQ:
        begin
          if (accept)
          begin
            state                 <= S_ACKED;
            ack                   <= 1'b1;
            lane_load[pkt.stream] <= 1'b1; // Only the tagged lane sees the pulse.
          end
        end
        S_ACKED:
        begin
          if (!req)
          begin
            state <= S_WAIT_REQ;
            ack   <= 1'b0;
          end
          else
            state <= S_WAIT_LOW;
        end
        S_WAIT_LOW:
        begin
          if (!req)
          begin
            state <= S_WAIT_REQ;
            ack   <= 1'b0;
          end
        end
        default:
          state <= S_WAIT_REQ;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      lane_cmd.value <= pkt.code[6];
      lane_cmd.run   <= pkt.code[5:0];
      lane_cmd.eob   <= pkt.eob;
    end
  end

endmodule

// File: src/decompressor.sv
`timescale 1ns/1ps
`include "io_params.svh"

module decompressor #(
  parameter int W = `IO_WORD_W
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  io_bus_pkg::lane_cmd_t cmd,
  output logic                  idle,
  input  logic                  full,
  output logic                  store,
  output logic [W-1:0]          word
);

  localparam int FILL_W = $clog2(W);

  logic [5:0]        run_left;
  logic              bit_val;
  logic              flush_pend;
  logic [FILL_W-1:0] fill;
  logic [W-1:0]      shift_q;
  logic              store_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      run_left   <= '0;
      bit_val    <= 1'b0;
      flush_pend <= 1'b0;
      fill       <= '0;
      shift_q    <= '0;
      store_q    <= 1'b0;
    end
    else
    begin
      if (store_q)
      begin
        if (!full)
        begin
          store_q <= 1'b0;
          shift_q <= '0; // Unwritten bits of the next word stay zero for padding.
        end
      end
      else if (run_left != 6'd0)
      begin
        shift_q[fill] <= bit_val;
        run_left      <= run_left - 6'd1;
        if (fill == FILL_W'(W - 1))
        begin
          fill    <= '0;
          store_q <= 1'b1;
        end
        else
          fill <= fill + 1'b1;
      end
      else if (flush_pend)
      begin
        flush_pend <= 1'b0;
        if (fill != '0)
        begin
          fill    <= '0;
          store_q <= 1'b1;
        end
      end
      if (load)
      begin
        run_left   <= cmd.run;
        bit_val    <= cmd.value;
        flush_pend <= cmd.eob;
      end
    end
  end

  assign idle  = (run_left == 6'd0) && !flush_pend;
  assign store = store_q;
  assign word  = shift_q;

endmodule

// File: src/memory_manager.sv
`timescale 1ns/1ps
`include "io_params.svh"

module memory_manager #(
  parameter int W = `IO_WORD_W
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                store_a,
  input  logic [W-1:0]        word_a,
  output logic                full_a,
  input  logic                store_b,
  input  logic [W-1:0]        word_b,
  output logic                full_b,
  output logic                wr_en,
  output io_mem_pkg::wr_req_t wr,
  output logic                pending
);

  localparam int AW = io_mem_pkg::ADDR_W;

  logic [W-1:0]      hold_a;
  logic [W-1:0]      hold_b;
  logic              valid_a;
  logic              valid_b;
  logic              prio_b;
  logic              grant_b;
  io_mem_pkg::addr_t addr_a;
  io_mem_pkg::addr_t addr_b;

  assign grant_b = valid_b && (!valid_a || prio_b);
  assign wr_en   = valid_a || valid_b;
  assign wr.addr = grant_b ? addr_b : addr_a;
  assign wr.data = grant_b ? hold_b : hold_a;
  assign full_a  = valid_a;
  assign full_b  = valid_b;
  assign pending = valid_a || valid_b;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_a <= 1'b0;
      valid_b <= 1'b0;
      prio_b  <= 1'b0;
      addr_a  <= '0;
      addr_b  <= {1'b1, {(AW-1){1'b0}}}; // Second lane starts at the high half.
    end
    else
    begin
      if (valid_a && valid_b)
        prio_b <= !grant_b; // Loser of this conflict wins the next one.
      if (store_a && !valid_a)
        valid_a <= 1'b1;
      else if (valid_a && !grant_b)
      begin
        valid_a <= 1'b0;
        addr_a  <= {addr_a[AW-1], addr_a[AW-2:0] + 1'b1};
      end
      if (store_b && !valid_b)
        valid_b <= 1'b1;
      else if (grant_b)
      begin
        valid_b <= 1'b0;
        addr_b  <= {addr_b[AW-1], addr_b[AW-2:0] + 1'b1};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (store_a && !valid_a)
      hold_a <= word_a;
    if (store_b && !valid_b)
      hold_b <= word_b;
  end

endmodule

// File: src/ram_bank.sv
`timescale 1ns/1ps
`include "io_params.svh"

module ram_bank #(
  parameter int W     = `IO_WORD_W,
  parameter int DEPTH = `IO_BANK_DEPTH
) (
  input  logic                clk,
  input  logic                wr_en,
  input  io_mem_pkg::wr_req_t wr,
  input  io_mem_pkg::addr_t   rd_addr,
  output logic [W-1:0]        rd_data
);

  logic [W-1:0] mem [DEPTH];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr.addr] <= wr.data;
    rd_data <= mem[rd_addr]; // Read data follows the address by one cycle.
  end

endmodule

// File: src/io_module.sv
`timescale 1ns/1ps
`include "io_params.svh"

module io_module (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req,
  input  io_bus_pkg::host_pkt_t   pkt,
  output logic                    ack,
  output logic                    busy,
  input  logic                    rd_bank,
  input  io_mem_pkg::addr_t       rd_addr,
  output logic [`IO_WORD_W-1:0]   rd_data
);

  localparam int W = `IO_WORD_W;

  logic [3:0]            lane_idle;
  logic [3:0]            lane_load;
  logic [3:0]            lane_store;
  logic [3:0]            lane_full;
  logic [W-1:0]          lane_word [4];
  io_bus_pkg::lane_cmd_t lane_cmd;
  logic [1:0]            bank_wr_en;
  logic [1:0]            mgr_pending;
  io_mem_pkg::wr_req_t   bank_wr [2];
  logic [W-1:0]          bank_rd [2];
  logic                  rd_bank_q;

  io_fsm u_io_fsm (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .pkt       (pkt),
    .ack       (ack),
    .lane_idle (lane_idle),
    .lane_load (lane_load),
    .lane_cmd  (lane_cmd)
  );

  for (genvar i = 0; i < 4; i++)
  begin : g_lane
    decompressor #(.W(W)) u_decompressor (
      .clk   (clk),
      .rst   (rst),
      .load  (lane_load[i]),
      .cmd   (lane_cmd),
      .idle  (lane_idle[i]),
      .full  (lane_full[i]),
      .store (lane_store[i]),
      .word  (lane_word[i])
    );
  end

  // Bank 0 holds A in the low half and control in the high half.
  memory_manager #(.W(W)) u_mgr0 (
    .clk     (clk),
    .rst     (rst),
    .store_a (lane_store[io_bus_pkg::STREAM_A]),
    .word_a  (lane_word[io_bus_pkg::STREAM_A]),
    .full_a  (lane_full[io_bus_pkg::STREAM_A]),
    .store_b (lane_store[io_bus_pkg::STREAM_CTRL]),
    .word_b  (lane_word[io_bus_pkg::STREAM_CTRL]),
    .full_b  (lane_full[io_bus_pkg::STREAM_CTRL]),
    .wr_en   (bank_wr_en[0]),
    .wr      (bank_wr[0]),
    .pending (mgr_pending[0])
  );

  memory_manager #(.W(W)) u_mgr1 (
    .clk     (clk),
    .rst     (rst),
    .store_a (lane_store[io_bus_pkg::STREAM_B]),
    .word_a  (lane_word[io_bus_pkg::STREAM_B]),
    .full_a  (lane_full[io_bus_pkg::STREAM_B]),
    .store_b (lane_store[io_bus_pkg::STREAM_U]),
    .word_b  (lane_word[io_bus_pkg::STREAM_U]),
    .full_b  (lane_full[io_bus_pkg::STREAM_U]),
    .wr_en   (bank_wr_en[1]),
    .wr      (bank_wr[1]),
    .pending (mgr_pending[1])
  );

  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    ram_bank #(.W(W), .DEPTH(`IO_BANK_DEPTH)) u_ram_bank (
      .clk     (clk),
      .wr_en   (bank_wr_en[b]),
      .wr      (bank_wr[b]),
      .rd_addr (rd_addr),
      .rd_data (bank_rd[b])
    );
  end

  // A word still held by a lane counts as work in flight.
  assign busy = !(&lane_idle) || (|lane_store) || (|mgr_pending);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      rd_bank_q <= 1'b0;
    else
      rd_bank_q <= rd_bank; // Aligns the bank select with the registered read.
  end

  assign rd_data = rd_bank_q ? bank_rd[1] : bank_rd[0];

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter realtime PERIOD = 40.0
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD / 2.0) clk = ~clk; // Free running for the whole run.
  end

endmodule

// File: test/io_module_assert.sv
`timescale 1ns/1ps

module io_module_assert (
  input logic       clk,
  input logic       rst,
  input logic       req,
  input logic       ack,
  input logic [1:0] bank_wr_en
);

  // The host drops req in the cycle after ack rises, so the accepting edge is one back.
  ack_rise_with_req : assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
    else $error("ack rose without a pending request");

  ack_fall_after_req_low : assert property (@(posedge clk) disable iff (rst)
    $fell(ack) |-> $past(!req))
    else $error("ack fell while the request was still high");

  no_write_in_reset : assert property (@(posedge clk) rst |-> (bank_wr_en == 2'b00))
    else $error("bank write enable active during reset");

  no_ack_in_reset : assert property (@(posedge clk) rst |-> !ack)
    else $error("ack high during reset");

endmodule

bind io_module io_module_assert u_io_module_assert (
  .clk        (clk),
  .rst        (rst),
  .req        (req),
  .ack        (ack),
  .bank_wr_en (bank_wr_en)
);

// File: test/io_module_tb.sv
`timescale 1ns/1ps
`include "io_params.svh"

module io_module_tb;

  localparam int W      = `IO_WORD_W;
  localparam int DEPTH  = `IO_BANK_DEPTH;
  localparam int HALF   = DEPTH / 2;
  localparam int MARGIN = 6000; // Covers reset, handshakes and all read-back passes.

  logic                  clk;
  logic                  rst;
  logic                  req;
  io_bus_pkg::host_pkt_t pkt;
  logic                  ack;
  logic                  busy;
  logic                  rd_bank;
  io_mem_pkg::addr_t     rd_addr;
  logic [W-1:0]          rd_data;

  logic [W-1:0] exp_mem [2][DEPTH];
  bit           exp_valid [2][DEPTH];
  logic [W-1:0] part_word [4];
  int           part_fill [4];
  int           word_idx [4];
  int           errors;
  int           checks;
  int           cycle;
  int           bits_sent;

  tb_clock #(.PERIOD(40.0)) u_tb_clock (.clk(clk));

  io_module u_io_module (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .pkt     (pkt),
    .ack     (ack),
    .busy    (busy),
    .rd_bank (rd_bank),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle > `IO_TIMEOUT_BASE * bits_sent + MARGIN)
    begin
      $display("Timeout after %0d cycles, the DUT stopped responding.", cycle);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [W-1:0] exp, input logic [W-1:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  // A and control share bank 0, B and U share bank 1; the second lane owns the high half.
  task automatic commit_word(input int s);
    int bank;
    int addr;
    bank = (s == 0 || s == 3) ? 0 : 1;
    addr = ((s == 0 || s == 1) ? 0 : HALF) + (word_idx[s] % HALF);
    exp_mem[bank][addr]   = part_word[s];
    exp_valid[bank][addr] = 1'b1;
    word_idx[s]++;
    part_word[s] = '0;
    part_fill[s] = 0;
  endtask

  task automatic model_byte(input int s, input logic eob, input logic v, input int run);
    for (int i = 0; i < run; i++)
    begin
      part_word[s][part_fill[s]] = v; // Bits fill from the LSB upward.
      part_fill[s]++;
      if (part_fill[s] == W)
        commit_word(s);
    end
    if (eob && part_fill[s] != 0)
      commit_word(s);
  endtask

  task automatic send_byte(input int s, input logic eob, input logic v, input int run,
                           output int ack_cycle);
    model_byte(s, eob, v, run);
    bits_sent += run + 1;
    @(negedge clk);
    pkt.stream = io_bus_pkg::stream_t'(s[1:0]);
    pkt.eob    = eob;
    pkt.code   = {1'b0, v, 6'(run)};
    req        = 1'b1;
    while (!ack)
      @(negedge clk);
    ack_cycle = cycle;
    req       = 1'b0;
    while (ack)
      @(negedge clk);
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (busy)
      @(negedge clk);
  endtask

  task automatic read_word(input int bank, input int addr, output logic [W-1:0] data);
    @(negedge clk);
    rd_bank = bank[0];
    rd_addr = io_mem_pkg::addr_t'(addr);
    @(negedge clk);
    data = rd_data;
  endtask

  task automatic check_banks(input string name);
    logic [W-1:0] got;
    for (int b = 0; b < 2; b++)
      for (int a = 0; a < DEPTH; a++)
        if (exp_valid[b][a])
        begin
          read_word(b, a, got);
          check_value($sformatf("%s bank %0d addr %0d", name, b, a), exp_mem[b][a], got);
        end
  endtask

  task automatic test_reset_state();
    int t;
    check_value("reset_state ack", '0, W'(ack));
    check_value("reset_state busy", '0, W'(busy));
    send_byte(0, 1'b1, 1'b1, 5, t);
    wait_idle();
    check_banks("reset_state");
  endtask

  task automatic test_full_word();
    int t;
    send_byte(1, 1'b0, 1'b1, 10, t);
    send_byte(1, 1'b0, 1'b0, 6, t);
    send_byte(1, 1'b0, 1'b1, W - 16, t);
    send_byte(1, 1'b1, 1'b0, 0, t); // Empty word, so nothing extra is stored.
    wait_idle();
    check_banks("full_word");
  endtask

  task automatic test_run_crossing();
    int t;
    send_byte(2, 1'b0, 1'b1, 20, t);
    send_byte(2, 1'b0, 1'b0, 30, t);
    send_byte(2, 1'b1, 1'b1, 25, t);
    wait_idle();
    check_banks("run_crossing");
  endtask

  task automatic test_shared_bank();
    int t;
    for (int i = 0; i < 6; i++)
    begin
      send_byte(0, 1'b0, i[0], 7 + 5 * i, t);
      send_byte(3, 1'b0, !i[0], 50 - 4 * i, t);
    end
    send_byte(0, 1'b1, 1'b1, 3, t);
    send_byte(3, 1'b1, 1'b0, 0, t);
    wait_idle();
    check_banks("shared_bank");
  endtask

  task automatic test_random_mix();
    int t;
    for (int i = 0; i < 40; i++)
      send_byte($urandom % 4, ($urandom % 8) == 0, $urandom % 2, $urandom % 64, t);
    for (int s = 0; s < 4; s++)
      send_byte(s, 1'b1, 1'b0, 0, t);
    wait_idle();
    check_banks("random_mix");
  endtask

  task automatic test_back_pressure();
    int t0;
    int t1;
    int gap;
    send_byte(0, 1'b0, 1'b1, 63, t0);
    send_byte(0, 1'b1, 1'b0, 40, t1); // Lane A is still expanding here.
    gap = t1 - t0;
    checks++;
    assert (gap > 63)
    else
    begin
      errors++;
      $display("** Error: back_pressure ack gap expected more than %0d actual %0d", 63, gap);
    end
    wait_idle();
    check_banks("back_pressure");
  endtask

  initial
  begin
    rst       = 1'b1;
    req       = 1'b0;
    pkt       = '0;
    rd_bank   = 1'b0;
    rd_addr   = '0;
    errors    = 0;
    checks    = 0;
    bits_sent = 0;
    for (int s = 0; s < 4; s++)
    begin
      part_word[s] = '0;
      part_fill[s] = 0;
      word_idx[s]  = 0;
    end
    void'($urandom(32254));
    repeat (16)
      @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_full_word();
    test_run_crossing();
    test_shared_bank();
    test_random_mix();
    test_back_pressure();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: build.f
+incdir+include
src/io_bus_pkg.sv
src/io_mem_pkg.sv
src/io_fsm.sv
src/decompressor.sv
src/memory_manager.sv
src/ram_bank.sv
src/io_module.sv
test/tb_clock.sv
test/io_module_assert.sv
test/io_module_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f build.f --top-module io_module_tb -o io_sim \
  && ./obj_dir/io_sim | tee /dev/stderr | grep "All tests passed!" > /dev/null \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }
